// File: Makefile
TOP       ?= tbMmuTop
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0
FILELIST  ?= mmuTop.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// File: hdl/addrTranslate.sv
`timescale 1ns/1ps

module addrTranslate #(
    parameter int idxW = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  mmuPkg::transReqT    req,
    input  mmuPkg::crmdT        crmd,
    input  mmuPkg::dmwT         dmw0,
    input  mmuPkg::dmwT         dmw1,
    input  logic                stallT,
    input  logic                flushT,
    input  logic                hit,
    input  mmuPkg::tlbPageT     page,
    input  logic [5:0]          ps,
    output mmuPkg::transRespT   resp
);

    import mmuPkg::*;

    logic             dmw0Hit;
    logic             dmw1Hit;
    logic [PALEN-1:0] pageMask;
    logic [PALEN-1:0] pagedAddr;
    transRespT        respNext;

    function automatic excpT mkExcp(input logic v, input logic [8:0] sub, input excpCodeE c);
        excpT e;
        e.valid = v;
        e.subcode = sub;
        e.code = c;
        return e;
    endfunction

    function automatic logic dmwHit(input dmwT w, input logic [1:0] plv, input logic [2:0] seg);
        return ((w.plv0 && plv == 2'd0) || (w.plv3 && plv == 2'd3)) && w.vseg == seg;
    endfunction

    assign dmw0Hit = dmwHit(dmw0, crmd.plv, req.vaddr[31:29]);
    assign dmw1Hit = dmwHit(dmw1, crmd.plv, req.vaddr[31:29]);
    assign pageMask = {PALEN{1'b1}} << ps; // bits taken from ppn
    assign pagedAddr = ({page.ppn, {PAGE_OFS{1'b0}}} & pageMask) | (req.vaddr & ~pageMask);

    always_comb
    begin
        respNext.paddr = pagedAddr;
        respNext.memtype = page.mat;
        respNext.excp = '0;
        if (crmd.da && !crmd.pg)
        begin
            respNext.paddr = req.vaddr;
            respNext.memtype = (req.op == FETCH) ? crmd.datf : crmd.datm;
        end
        else if (dmw0Hit)
        begin
            respNext.paddr = {dmw0.pseg, req.vaddr[28:0]};
            respNext.memtype = dmw0.mat;
        end
        else if (dmw1Hit)
        begin
            respNext.paddr = {dmw1.pseg, req.vaddr[28:0]};
            respNext.memtype = dmw1.mat;
        end
        else if (crmd.plv != 2'd0 && req.vaddr[31])
            respNext.excp = mkExcp(req.valid, (req.op == FETCH) ? ADEF : ADEM, ADE);
        else if (!hit)
            respNext.excp = mkExcp(req.valid, 9'h0, TLBR);
        else if (!page.v)
        begin
            case (req.op)
                FETCH:   respNext.excp = mkExcp(req.valid, 9'h0, PIF);
                LOAD:    respNext.excp = mkExcp(req.valid, 9'h0, PIL);
                default: respNext.excp = mkExcp(req.valid, 9'h0, PIS);
            endcase
        end
        else if (crmd.plv > page.plv)
            respNext.excp = mkExcp(req.valid, 9'h0, PPI);
        else if (req.op == STORE && !page.d)
            respNext.excp = mkExcp(req.valid, 9'h0, PME); // clean page store
    end

    // flush has priority over stall
    always_ff @(posedge clk)
    begin
        if (rst || flushT)
            resp <= '0;
        else if (!stallT)
            resp <= respNext;
    end

endmodule

// File: hdl/mmuPkg.sv
package mmuPkg;

    localparam int PALEN = 32;
    localparam int VALEN = 32;
    localparam int PAGE_OFS = 12;

    localparam logic [8:0] ADEF = 9'h000; // fetch address error
    localparam logic [8:0] ADEM = 9'h001; // load/store address error

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } memOpE;

    typedef enum logic [4:0] {
        TLBSRCH = 5'd1,
        TLBRD   = 5'd2,
        TLBWR   = 5'd3,
        TLBFILL = 5'd4,
        INVTLB  = 5'd5
    } tlbOpE;

    typedef enum logic [3:0] {
        PRIV_MMU = 4'd10,
        MMU      = 4'd11
    } instrClassE;

    typedef enum logic [5:0] {
        NONE = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADE  = 6'h08,
        TLBR = 6'h3f
    } excpCodeE;

    typedef struct packed {
        logic       valid;
        logic [8:0] subcode;
        excpCodeE   code;
    } excpT;

    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmdT;

    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsv0;
        logic [2:0]  pseg;
        logic [18:0] rsv1;
        logic [1:0]  mat;
        logic        plv3;
        logic [1:0]  rsv2;
        logic        plv0;
    } dmwT;

    typedef struct packed {
        logic [PALEN-PAGE_OFS-1:0] ppn;
        logic [1:0]                plv;
        logic [1:0]                mat;
        logic                      d;
        logic                      v;
    } tlbPageT;

    typedef struct packed {
        logic                      e;
        logic [VALEN-PAGE_OFS-2:0] vppn; // vaddr[31:13]
        logic [5:0]                ps;
        logic                      g;
        logic [9:0]                asid;
        tlbPageT                   even;
        tlbPageT                   odd;
    } tlbEntryT;

    typedef struct packed {
        logic [31:0] tlbidx;
        logic [31:0] tlbehi;
        logic [31:0] tlbelo0;
        logic [31:0] tlbelo1;
        logic [9:0]  asid;
    } csrSetT;

    typedef struct packed {
        instrClassE cls;
        tlbOpE      sub;
        logic [4:0] invOp;
        logic [9:0] rjAsid;
    } tlbCmdT;

    typedef struct packed {
        logic [VALEN-1:0] vaddr;
        memOpE            op;
        logic             valid;
    } transReqT;

    typedef struct packed {
        logic [PALEN-1:0] paddr;
        excpT             excp;
        logic [1:0]       memtype;
    } transRespT;

endpackage

// File: hdl/mmuTop.sv
`timescale 1ns/1ps

module mmuTop #(
    parameter int idxW = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  mmuPkg::tlbCmdT      cmd,
    input  mmuPkg::csrSetT      csrIn,
    input  mmuPkg::crmdT        crmd,
    input  mmuPkg::dmwT         dmw0,
    input  mmuPkg::dmwT         dmw1,
    input  logic                stallW,
    input  logic                flushW,
    input  mmuPkg::transReqT    req,
    input  logic                stallT,
    input  logic                flushT,
    output mmuPkg::csrSetT      csrOut,
    output mmuPkg::transRespT   resp
);

    import mmuPkg::*;

    logic                         wrEn;
    logic                         invEn;
    logic [idxW-1:0]              wrIdx;
    tlbEntryT                     wrEntry;
    logic [4:0]                   invOp;
    logic [9:0]                   invAsid;
    tlbEntryT [(1<<idxW)-1:0]     entries;
    logic                         srchHit;
    logic [idxW-1:0]              srchIdx;
    logic                         transHit;
    tlbPageT                      transPage;
    logic [5:0]                   transPs;

    tlbCsrUnit #(.idxW(idxW)) u_csrUnit (
        .clk(clk), .rst(rst), .cmd(cmd), .csrIn(csrIn),
        .stallW(stallW), .flushW(flushW), .entries(entries),
        .srchHit(srchHit), .srchIdx(srchIdx),
        .wrEn(wrEn), .invEn(invEn), .wrIdx(wrIdx), .wrEntry(wrEntry),
        .invOp(invOp), .invAsid(invAsid), .csrOut(csrOut)
    );

    tlbArray #(.idxW(idxW)) u_tlbArray (
        .clk(clk), .rst(rst), .wrEn(wrEn), .wrIdx(wrIdx), .wrEntry(wrEntry),
        .invEn(invEn), .invOp(invOp), .invAsid(invAsid), .entries(entries)
    );

    // TLBSRCH key comes from TLBEHI
    tlbMatch #(.idxW(idxW)) u_srchMatch (
        .entries(entries), .vaddr(csrIn.tlbehi), .asid(csrIn.asid),
        .hit(srchHit), .idx(srchIdx), .page(), .ps()
    );

    tlbMatch #(.idxW(idxW)) u_transMatch (
        .entries(entries), .vaddr(req.vaddr), .asid(csrIn.asid),
        .hit(transHit), .idx(), .page(transPage), .ps(transPs)
    );

    addrTranslate #(.idxW(idxW)) u_addrTranslate (
        .clk(clk), .rst(rst), .req(req), .crmd(crmd), .dmw0(dmw0), .dmw1(dmw1),
        .stallT(stallT), .flushT(flushT), .hit(transHit), .page(transPage),
        .ps(transPs), .resp(resp)
    );

endmodule

// File: hdl/tlbArray.sv
`timescale 1ns/1ps

module tlbArray #(
    parameter int idxW = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wrEn,
    input  logic [idxW-1:0]                     wrIdx,
    input  mmuPkg::tlbEntryT                    wrEntry,
    input  logic                                invEn,
    input  logic [4:0]                          invOp,
    input  logic [9:0]                          invAsid,
    output mmuPkg::tlbEntryT [(1<<idxW)-1:0]    entries
);

    localparam int nEntry = 1 << idxW;

    logic [nEntry-1:0] invHit;

    // per entry invalidate select
    always_comb
    begin
        for (int i = 0; i < nEntry; i++)
        begin
            case (invOp)
                5'd0, 5'd1:
                    invHit[i] = 1'b1;
                5'd2:
                    invHit[i] = entries[i].g; // global only
                5'd3:
                    invHit[i] = !entries[i].g; // non-global only
                5'd4:
                    invHit[i] = !entries[i].g && entries[i].asid == invAsid;
                default:
                    invHit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            entries <= '0;
        end
        else
        begin
            for (int i = 0; i < nEntry; i++)
            begin
                if (wrEn && wrIdx == idxW'(i))
                begin
                    entries[i] <= wrEntry;
                end
                else if (invEn && invHit[i])
                begin
                    entries[i].e <= 1'b0; // rest of entry kept
                end
            end
        end
    end

endmodule

// File: hdl/tlbCsrUnit.sv
`timescale 1ns/1ps

module tlbCsrUnit #(
    parameter int idxW = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  mmuPkg::tlbCmdT                      cmd,
    input  mmuPkg::csrSetT                      csrIn,
    input  logic                                stallW,
    input  logic                                flushW,
    input  mmuPkg::tlbEntryT [(1<<idxW)-1:0]    entries,
    input  logic                                srchHit,
    input  logic [idxW-1:0]                     srchIdx,
    output logic                                wrEn,
    output logic                                invEn,
    output logic [idxW-1:0]                     wrIdx,
    output mmuPkg::tlbEntryT                    wrEntry,
    output logic [4:0]                          invOp,
    output logic [9:0]                          invAsid,
    output mmuPkg::csrSetT                      csrOut
);

    import mmuPkg::*;

    logic     exe;
    tlbEntryT rdEntry;
    csrSetT   csrNext;

    function automatic tlbPageT loToPage(input logic [31:0] elo);
        tlbPageT p;
        p.ppn = elo[PALEN-5:8];
        p.plv = elo[3:2];
        p.mat = elo[5:4];
        p.d = elo[1];
        p.v = elo[0];
        return p;
    endfunction

    function automatic logic [31:0] pageToLo(input tlbPageT p, input logic g);
        logic [31:0] elo;
        elo = '0;
        elo[PALEN-5:8] = p.ppn;
        elo[6:0] = {g, p.mat, p.plv, p.d, p.v};
        return elo;
    endfunction

    assign exe = (cmd.cls == MMU || cmd.cls == PRIV_MMU) && !stallW && !flushW;
    assign wrIdx = csrIn.tlbidx[idxW-1:0]; // also the TLBRD index
    assign rdEntry = entries[wrIdx];
    assign wrEn = exe && (cmd.sub == TLBWR || cmd.sub == TLBFILL);
    assign invEn = exe && cmd.sub == INVTLB;
    assign invOp = cmd.invOp;
    assign invAsid = cmd.rjAsid;

    always_comb
    begin
        wrEntry.e = !csrIn.tlbidx[31]; // NE inverted
        wrEntry.vppn = csrIn.tlbehi[31:13];
        wrEntry.ps = csrIn.tlbidx[29:24];
        wrEntry.g = csrIn.tlbelo0[6] & csrIn.tlbelo1[6];
        wrEntry.asid = csrIn.asid;
        wrEntry.even = loToPage(csrIn.tlbelo0);
        wrEntry.odd = loToPage(csrIn.tlbelo1);
    end

    always_comb
    begin
        csrNext = csrIn;
        if (exe)
        begin
            case (cmd.sub)
                TLBSRCH:
                begin
                    csrNext.tlbidx[31] = !srchHit;
                    if (srchHit)
                        csrNext.tlbidx[idxW-1:0] = srchIdx;
                end
                TLBRD:
                begin
                    if (rdEntry.e)
                    begin
                        csrNext.tlbidx[31] = 1'b0;
                        csrNext.tlbidx[29:24] = rdEntry.ps;
                        csrNext.tlbehi[31:13] = rdEntry.vppn;
                        csrNext.tlbelo0 = pageToLo(rdEntry.even, rdEntry.g);
                        csrNext.tlbelo1 = pageToLo(rdEntry.odd, rdEntry.g);
                        csrNext.asid = rdEntry.asid;
                    end
                    else
                    begin
                        csrNext = '0;
                        csrNext.tlbidx[31] = 1'b1; // empty slot
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || (flushW && !stallW))
            csrOut <= '0;
        else if (!stallW)
            csrOut <= csrNext;
    end

endmodule

// File: hdl/tlbMatch.sv
`timescale 1ns/1ps

module tlbMatch #(
    parameter int idxW = 4
) (
    input  mmuPkg::tlbEntryT [(1<<idxW)-1:0]    entries,
    input  logic [mmuPkg::VALEN-1:0]            vaddr,
    input  logic [9:0]                          asid,
    output logic                                hit,
    output logic [idxW-1:0]                     idx,
    output mmuPkg::tlbPageT                     page,
    output logic [5:0]                          ps
);

    import mmuPkg::*;

    localparam int nEntry = 1 << idxW;

    logic [nEntry-1:0] entMatch;
    logic [VALEN-1:0]  vaddrShift;

    always_comb
    begin
        idx = '0;
        for (int i = 0; i < nEntry; i++)
        begin
            // compare vaddr[31:ps+1] against the stored vppn
            entMatch[i] = entries[i].e
                && (entries[i].g || entries[i].asid == asid)
                && (({entries[i].vppn, {PAGE_OFS{1'b0}}} >> entries[i].ps)
                    == (vaddr[VALEN-1:1] >> entries[i].ps));
            if (entMatch[i])
                idx = idxW'(i); // highest index wins
        end
    end

    assign hit = |entMatch;
    assign ps = entries[idx].ps;
    assign vaddrShift = vaddr >> ps;
    assign page = vaddrShift[0] ? entries[idx].odd : entries[idx].even; // odd/even half

endmodule

// File: mmuTop.f
hdl/mmuPkg.sv
hdl/tlbArray.sv
hdl/tlbMatch.sv
hdl/tlbCsrUnit.sv
hdl/addrTranslate.sv
hdl/mmuTop.sv
tb/tbMmuTop.sv

// File: tb/tbMmuTop.sv
`timescale 1ns/1ps

module tbMmuTop;

    import mmuPkg::*;

    localparam int IDXW = 4;
    localparam int NENT = 1 << IDXW;

    logic      clk;
    logic      rst;
    tlbCmdT    cmd;
    csrSetT    csrIn;
    csrSetT    csrOut;
    crmdT      crmd;
    dmwT       dmw0;
    dmwT       dmw1;
    logic      stallW;
    logic      flushW;
    transReqT  req;
    logic      stallT;
    logic      flushT;
    transRespT resp;

    tlbEntryT  shadow [NENT]; // mirror of the DUT table
    crmdT      curCrmd;
    dmwT       curDmw0;
    dmwT       curDmw1;
    csrSetT    curCsr;
    int        cyc = 0;
    int        errors = 0;
    int        seed = 2;

    // pending checks due at a cycle count
    string     tNameQ[$];
    transRespT tExpQ[$];
    int        tDueQ[$];
    string     cNameQ[$];
    csrSetT    cExpQ[$];
    int        cDueQ[$];

    mmuTop #(.idxW(IDXW)) u_dut (
        .clk(clk), .rst(rst), .cmd(cmd), .csrIn(csrIn), .crmd(crmd),
        .dmw0(dmw0), .dmw1(dmw1), .stallW(stallW), .flushW(flushW),
        .req(req), .stallT(stallT), .flushT(flushT),
        .csrOut(csrOut), .resp(resp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    function automatic logic [31:0] mkLo(input logic [19:0] ppn, input logic [1:0] plv,
                                         input logic [1:0] mat, input logic d,
                                         input logic v, input logic g);
        logic [31:0] lo;
        lo = '0;
        lo[27:8] = ppn;
        lo[6] = g;
        lo[5:4] = mat;
        lo[3:2] = plv;
        lo[1] = d;
        lo[0] = v;
        return lo;
    endfunction

    function automatic tlbPageT pageFromLo(input logic [31:0] lo);
        tlbPageT p;
        p.ppn = lo[27:8];
        p.plv = lo[3:2];
        p.mat = lo[5:4];
        p.d = lo[1];
        p.v = lo[0];
        return p;
    endfunction

    function automatic csrSetT mkCsr(input logic [IDXW-1:0] idx, input logic [31:0] va,
                                     input logic [5:0] ps, input logic [9:0] asid,
                                     input logic [31:0] lo0, input logic [31:0] lo1);
        csrSetT c;
        c = '0;
        c.tlbidx[29:24] = ps;
        c.tlbidx[IDXW-1:0] = idx;
        c.tlbehi = va & 32'hffffe000;
        c.tlbelo0 = lo0;
        c.tlbelo1 = lo1;
        c.asid = asid;
        return c;
    endfunction

    function automatic tlbCmdT mkCmd(input tlbOpE sub, input logic [4:0] op,
                                     input logic [9:0] asid);
        tlbCmdT c;
        c.cls = (sub == INVTLB) ? PRIV_MMU : MMU;
        c.sub = sub;
        c.invOp = op;
        c.rjAsid = asid;
        return c;
    endfunction

    function automatic crmdT mkCrmd(input logic da, input logic pg, input logic [1:0] plv,
                                    input logic [1:0] datf, input logic [1:0] datm);
        crmdT c;
        c = '0;
        c.da = da;
        c.pg = pg;
        c.plv = plv;
        c.datf = datf;
        c.datm = datm;
        return c;
    endfunction

    function automatic dmwT mkDmw(input logic [2:0] vseg, input logic [2:0] pseg,
                                  input logic [1:0] mat, input logic plv0, input logic plv3);
        dmwT w;
        w = '0;
        w.vseg = vseg;
        w.pseg = pseg;
        w.mat = mat;
        w.plv0 = plv0;
        w.plv3 = plv3;
        return w;
    endfunction

    // highest matching entry or -1 on a miss
    function automatic int findEntry(input logic [31:0] va, input logic [9:0] asid);
        int found;
        found = -1;
        for (int i = 0; i < NENT; i++)
        begin
            if (shadow[i].e && (shadow[i].g || shadow[i].asid == asid)
                && (va >> (shadow[i].ps + 1)) == ({shadow[i].vppn, 13'h0} >> (shadow[i].ps + 1)))
                found = i;
        end
        return found;
    endfunction

    function automatic logic windowAllows(input dmwT w, input logic [1:0] plv,
                                          input logic [2:0] seg);
        return ((w.plv0 && plv == 2'd0) || (w.plv3 && plv == 2'd3)) && w.vseg == seg;
    endfunction

    function automatic transRespT expectResp(input transReqT r, input crmdT c, input dmwT w0,
                                             input dmwT w1, input logic [9:0] asid);
        transRespT e;
        tlbPageT   pg;
        int        h;
        int        ps;
        logic [31:0] mask;
        e = '0;
        if (c.da && !c.pg)
        begin
            e.paddr = r.vaddr;
            e.memtype = (r.op == FETCH) ? c.datf : c.datm;
            return e;
        end
        if (windowAllows(w0, c.plv, r.vaddr[31:29]))
        begin
            e.paddr = {w0.pseg, r.vaddr[28:0]};
            e.memtype = w0.mat;
            return e;
        end
        if (windowAllows(w1, c.plv, r.vaddr[31:29]))
        begin
            e.paddr = {w1.pseg, r.vaddr[28:0]};
            e.memtype = w1.mat;
            return e;
        end
        e.excp.valid = r.valid;
        if (c.plv != 2'd0 && r.vaddr[31])
        begin
            e.excp.code = ADE;
            e.excp.subcode = (r.op == FETCH) ? ADEF : ADEM;
            return e;
        end
        h = findEntry(r.vaddr, asid);
        if (h < 0)
        begin
            e.excp.code = TLBR;
            return e;
        end
        ps = int'(shadow[h].ps);
        pg = r.vaddr[ps] ? shadow[h].odd : shadow[h].even;
        mask = 32'hffffffff << ps;
        e.paddr = ({pg.ppn, 12'h0} & mask) | (r.vaddr & ~mask);
        e.memtype = pg.mat;
        if (!pg.v)
            e.excp.code = (r.op == FETCH) ? PIF : ((r.op == LOAD) ? PIL : PIS);
        else if (c.plv > pg.plv)
            e.excp.code = PPI;
        else if (r.op == STORE && !pg.d)
            e.excp.code = PME;
        if (e.excp.code == NONE)
            e.excp.valid = 1'b0; // no exception raised
        return e;
    endfunction

    function automatic csrSetT expectCsr(input tlbOpE sub, input csrSetT c);
        csrSetT   o;
        tlbEntryT en;
        int       i;
        o = c;
        if (sub == TLBSRCH)
        begin
            i = findEntry(c.tlbehi, c.asid);
            o.tlbidx[31] = (i < 0);
            if (i >= 0)
                o.tlbidx[IDXW-1:0] = IDXW'(i);
        end
        else if (sub == TLBRD)
        begin
            en = shadow[c.tlbidx[IDXW-1:0]];
            if (en.e)
            begin
                o.tlbidx[31] = 1'b0;
                o.tlbidx[29:24] = en.ps;
                o.tlbehi[31:13] = en.vppn;
                o.tlbelo0 = mkLo(en.even.ppn, en.even.plv, en.even.mat, en.even.d,
                                 en.even.v, en.g);
                o.tlbelo1 = mkLo(en.odd.ppn, en.odd.plv, en.odd.mat, en.odd.d,
                                 en.odd.v, en.g);
                o.asid = en.asid;
            end
            else
            begin
                o = '0;
                o.tlbidx[31] = 1'b1;
            end
        end
        return o;
    endfunction

    function automatic void writeShadow(input csrSetT c);
        tlbEntryT n;
        n.e = !c.tlbidx[31];
        n.vppn = c.tlbehi[31:13];
        n.ps = c.tlbidx[29:24];
        n.g = c.tlbelo0[6] & c.tlbelo1[6];
        n.asid = c.asid;
        n.even = pageFromLo(c.tlbelo0);
        n.odd = pageFromLo(c.tlbelo1);
        shadow[c.tlbidx[IDXW-1:0]] = n;
    endfunction

    function automatic void invShadow(input logic [4:0] op, input logic [9:0] asid);
        logic kill;
        for (int i = 0; i < NENT; i++)
        begin
            case (op)
                5'd0, 5'd1: kill = 1'b1;
                5'd2:       kill = shadow[i].g;
                5'd3:       kill = !shadow[i].g;
                5'd4:       kill = !shadow[i].g && shadow[i].asid == asid;
                default:    kill = 1'b0;
            endcase
            if (kill)
                shadow[i].e = 1'b0;
        end
    endfunction

    task automatic checkVal(input string name, input logic [137:0] exp, input logic [137:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // result is registered at the next edge and read at the negedge after it
    task automatic pushTrans(input string name, input transRespT e);
        tNameQ.push_back(name);
        tExpQ.push_back(e);
        tDueQ.push_back(cyc + 2);
    endtask

    task automatic doTrans(input string name, input memOpE op, input logic [31:0] va);
        transReqT r;
        r.vaddr = va;
        r.op = op;
        r.valid = 1'b1;
        @(posedge clk);
        req <= r;
        stallT <= 1'b0;
        flushT <= 1'b0;
        pushTrans(name, expectResp(r, curCrmd, curDmw0, curDmw1, curCsr.asid));
    endtask

    task automatic doCmd(input string name, input tlbCmdT tc, input csrSetT c,
                         input logic sw, input logic fw);
        csrSetT e;
        if (sw)
            e = curCsr; // held from the idle cycle before
        else if (fw)
            e = '0;
        else
            e = expectCsr(tc.sub, c);
        @(posedge clk);
        cmd <= tc;
        csrIn <= c;
        stallW <= sw;
        flushW <= fw;
        curCsr = c;
        cNameQ.push_back(name);
        cExpQ.push_back(e);
        cDueQ.push_back(cyc + 2);
        if (!sw && !fw)
        begin
            if (tc.sub == TLBWR || tc.sub == TLBFILL)
                writeShadow(c);
            else if (tc.sub == INVTLB)
                invShadow(tc.invOp, tc.rjAsid);
        end
        @(posedge clk);
        cmd <= '0;
        stallW <= 1'b0;
        flushW <= 1'b0;
    endtask

    task automatic doSearch(input string name, input logic [31:0] va, input logic [9:0] asid);
        doCmd(name, mkCmd(TLBSRCH, 5'd0, 10'd0),
              mkCsr(4'd0, va, 6'd0, asid, $random(seed), $random(seed)), 1'b0, 1'b0);
    endtask

    task automatic setMode(input crmdT c, input dmwT w0, input dmwT w1, input logic [9:0] asid);
        @(posedge clk);
        curCrmd = c;
        curDmw0 = w0;
        curDmw1 = w1;
        curCsr.asid = asid;
        crmd <= c;
        dmw0 <= w0;
        dmw1 <= w1;
        csrIn <= curCsr;
    endtask

    task automatic loadEntries();
        doCmd("wr idx1", mkCmd(TLBWR, 5'd0, 10'd0),
              mkCsr(4'd1, 32'h00012000, 6'd12, 10'h11,
                    mkLo(20'h80001, 2'd0, 2'd1, 1'b1, 1'b1, 1'b0),
                    mkLo(20'h80002, 2'd0, 2'd1, 1'b0, 1'b1, 1'b0)), 1'b0, 1'b0);
        doCmd("wr idx2", mkCmd(TLBWR, 5'd0, 10'd0),
              mkCsr(4'd2, 32'h00400000, 6'd21, 10'h33,
                    mkLo(20'h1A000, 2'd0, 2'd0, 1'b1, 1'b0, 1'b1),
                    mkLo(20'h1B000, 2'd0, 2'd2, 1'b1, 1'b1, 1'b1)), 1'b0, 1'b0);
        doCmd("wr idx3", mkCmd(TLBWR, 5'd0, 10'd0),
              mkCsr(4'd3, 32'h00030000, 6'd12, 10'h22,
                    mkLo(20'h90003, 2'd3, 2'd1, 1'b1, 1'b1, 1'b0),
                    mkLo(20'h90004, 2'd3, 2'd1, 1'b1, 1'b1, 1'b0)), 1'b0, 1'b0);
        doCmd("fill idx4", mkCmd(TLBFILL, 5'd0, 10'd0),
              mkCsr(4'd4, 32'h00050000, 6'd12, 10'h44,
                    mkLo(20'hA0005, 2'd0, 2'd3, 1'b1, 1'b1, 1'b1),
                    mkLo(20'hA0006, 2'd0, 2'd3, 1'b1, 1'b1, 1'b1)), 1'b0, 1'b0);
    endtask

    always @(negedge clk)
    begin
        while (tDueQ.size() > 0 && tDueQ[0] == cyc)
        begin
            if (tExpQ[0].excp.code != NONE)
                checkVal({tNameQ[0], " excp"}, 138'(tExpQ[0].excp), 138'(resp.excp));
            else
                checkVal(tNameQ[0], 138'(tExpQ[0]), 138'(resp));
            void'(tNameQ.pop_front());
            void'(tExpQ.pop_front());
            void'(tDueQ.pop_front());
        end
        while (cDueQ.size() > 0 && cDueQ[0] == cyc)
        begin
            checkVal(cNameQ[0], 138'(cExpQ[0]), 138'(csrOut));
            void'(cNameQ.pop_front());
            void'(cExpQ.pop_front());
            void'(cDueQ.pop_front());
        end
    end

    initial
    begin
        #100000;
        $display("simulation timed out before the stimulus finished");
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        transReqT sreq;
        transRespT sexp;
        logic [31:0] off;
        int drain;
        rst = 1'b1;
        cmd = '0;
        csrIn = '0;
        crmd = '0;
        dmw0 = '0;
        dmw1 = '0;
        stallW = 1'b0;
        flushW = 1'b0;
        req = '0;
        stallT = 1'b0;
        flushT = 1'b0;
        curCrmd = '0;
        curDmw0 = '0;
        curDmw1 = '0;
        curCsr = '0;
        for (int i = 0; i < NENT; i++)
            shadow[i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkVal("reset resp", '0, 138'(resp));
        checkVal("reset csrOut", '0, 138'(csrOut));

        // direct address mode
        setMode(mkCrmd(1'b1, 1'b0, 2'd0, 2'd1, 2'd2), '0, '0, 10'h11);
        for (int i = 0; i < 6; i++)
            doTrans("direct", memOpE'(2'(i % 3)), $random(seed));

        // direct mapped windows
        setMode(mkCrmd(1'b0, 1'b1, 2'd0, 2'd0, 2'd0), mkDmw(3'd2, 3'd1, 2'd1, 1'b1, 1'b0),
                mkDmw(3'd3, 3'd6, 2'd2, 1'b0, 1'b1), 10'h11);
        off = $random(seed);
        doTrans("dmw0 plv0", LOAD, {3'd2, off[28:0]});
        doTrans("dmw1 plv0 miss", FETCH, {3'd3, off[28:0]});
        setMode(mkCrmd(1'b0, 1'b1, 2'd3, 2'd0, 2'd0), curDmw0, curDmw1, 10'h11);
        off = $random(seed);
        doTrans("dmw1 plv3", STORE, {3'd3, off[28:0]});
        doTrans("dmw0 plv3 miss", LOAD, {3'd2, off[28:0]});
        setMode(mkCrmd(1'b0, 1'b1, 2'd0, 2'd0, 2'd0), mkDmw(3'd2, 3'd1, 2'd1, 1'b1, 1'b0),
                mkDmw(3'd2, 3'd5, 2'd3, 1'b1, 1'b0), 10'h11);
        doTrans("dmw0 over dmw1", LOAD, {3'd2, off[28:0]});

        // paged translation
        loadEntries();
        setMode(mkCrmd(1'b0, 1'b1, 2'd0, 2'd0, 2'd0), '0, '0, 10'h11);
        off = $random(seed) & 32'h00000fff;
        doTrans("4k even load", LOAD, 32'h00012000 | off);
        doTrans("4k odd load", LOAD, 32'h00013000 | off);
        doTrans("4k odd store pme", STORE, 32'h00013000 | off);
        off = $random(seed) & 32'h001fffff;
        doTrans("2m even fetch pif", FETCH, 32'h00400000 | off);
        doTrans("2m even load pil", LOAD, 32'h00400000 | off);
        doTrans("2m even store pis", STORE, 32'h00400000 | off);
        doTrans("2m odd store", STORE, 32'h00600000 | off);
        doTrans("asid mismatch", LOAD, 32'h00030000 | (off & 32'hfff));
        doTrans("global 4k", FETCH, 32'h00050000 | (off & 32'hfff));
        setMode(mkCrmd(1'b0, 1'b1, 2'd3, 2'd0, 2'd0), '0, '0, 10'h11);
        doTrans("2m odd ppi", LOAD, 32'h00600000 | off);
        doTrans("ppi over pme", STORE, 32'h00013000 | (off & 32'hfff));
        doTrans("ade fetch", FETCH, 32'h80000000 | off);
        doTrans("ade load", LOAD, 32'h90000000 | off);
        setMode(mkCrmd(1'b0, 1'b1, 2'd3, 2'd0, 2'd0), '0, '0, 10'h22);
        doTrans("asid match plv3", STORE, 32'h00031000 | (off & 32'hfff));

        // search and read
        doSearch("srch idx1", 32'h00013000, 10'h11);
        doSearch("srch 2m", 32'h005ff000, 10'h11);
        doSearch("srch absent", 32'h00777000, 10'h11);
        doCmd("rd idx2", mkCmd(TLBRD, 5'd0, 10'd0),
              mkCsr(4'd2, $random(seed), 6'd3, 10'h155, $random(seed), $random(seed)),
              1'b0, 1'b0);
        doCmd("rd idx9", mkCmd(TLBRD, 5'd0, 10'd0),
              mkCsr(4'd9, $random(seed), 6'd3, 10'h155, $random(seed), $random(seed)),
              1'b0, 1'b0);

        // invalidate by each operation
        for (int op = 0; op < 5; op++)
        begin
            loadEntries();
            doCmd("invtlb", mkCmd(INVTLB, 5'(op), (op == 4) ? 10'h22 : 10'h0), curCsr,
                  1'b0, 1'b0);
            doSearch("inv srch idx1", 32'h00012000, 10'h11);
            doSearch("inv srch idx2", 32'h00400000, 10'h11);
            doSearch("inv srch idx3", 32'h00030000, 10'h22);
            doSearch("inv srch idx4", 32'h00050000, 10'h11);
            setMode(mkCrmd(1'b0, 1'b1, 2'd0, 2'd0, 2'd0), '0, '0, 10'h22);
            doTrans("inv trans idx3", LOAD, 32'h00030123);
            doTrans("inv trans idx4", LOAD, 32'h00050123);
        end

        // stall and flush of the translation stage
        loadEntries();
        setMode(mkCrmd(1'b0, 1'b1, 2'd0, 2'd0, 2'd0), '0, '0, 10'h11);
        sreq.vaddr = 32'h00012abc;
        sreq.op = LOAD;
        sreq.valid = 1'b1;
        sexp = expectResp(sreq, curCrmd, curDmw0, curDmw1, curCsr.asid);
        @(posedge clk);
        req <= sreq;
        pushTrans("stall first", sexp);
        @(posedge clk);
        req <= '{vaddr: 32'h00600010, op: LOAD, valid: 1'b1};
        stallT <= 1'b1;
        pushTrans("stall hold 1", sexp);
        @(posedge clk);
        req <= '{vaddr: 32'h00050020, op: FETCH, valid: 1'b1};
        pushTrans("stall hold 2", sexp);
        @(posedge clk);
        flushT <= 1'b1; // still stalled
        pushTrans("flush under stall", '0);
        doTrans("after flush", FETCH, 32'h00050020);

        // stalled or flushed write leaves the table alone
        doCmd("stallW wr", mkCmd(TLBWR, 5'd0, 10'd0),
              mkCsr(4'd7, 32'h00abc000, 6'd12, 10'h11,
                    mkLo(20'h12345, 2'd0, 2'd1, 1'b1, 1'b1, 1'b1),
                    mkLo(20'h12346, 2'd0, 2'd1, 1'b1, 1'b1, 1'b1)), 1'b1, 1'b0);
        doCmd("flushW wr", mkCmd(TLBWR, 5'd0, 10'd0),
              mkCsr(4'd8, 32'h00def000, 6'd12, 10'h11,
                    mkLo(20'h22345, 2'd0, 2'd1, 1'b1, 1'b1, 1'b1),
                    mkLo(20'h22346, 2'd0, 2'd1, 1'b1, 1'b1, 1'b1)), 1'b0, 1'b1);
        doSearch("srch after stallW", 32'h00abc000, 10'h11);
        doSearch("srch after flushW", 32'h00def000, 10'h11);

        drain = 0;
        while ((tDueQ.size() > 0 || cDueQ.size() > 0) && drain < 20)
        begin
            @(posedge clk);
            drain++;
        end
        if (tDueQ.size() > 0 || cDueQ.size() > 0)
        begin
            errors++;
            $display("checks were still pending when the final wait ran out");
        end
        @(posedge clk);
        $display("error count: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
